// ==== tests/icache_testdata.txt ====
# columns, all hex: fetch address, expected word (address xor a5c3), hit 1 or miss 0
# set 0 sees tags 010, 020 and 030 competing for two ways
0100 a4c3 0
0101 a4c2 1
0103 a4c0 1
0200 a7c3 0
0202 a7c1 1
0102 a4c1 1
0300 a6c3 0
0101 a4c2 1
0201 a7c2 0
0303 a6c0 0
0203 a7c0 1
0100 a4c3 0
# other sets
0104 a4c7 0
0107 a4c4 1
0a48 af8b 0
0a4b af88 1
1234 b7f7 0
1237 b7f4 1
0105 a4c6 1
fffc 5a3f 0
ffff 5a3c 1
# back to set 0
0202 a7c1 1
0300 a6c3 0
0102 a4c1 0

// ==== compile.f ====
+incdir+hw
hw/icache_pkg.sv
hw/way_if.sv
hw/icache_front.sv
hw/cache_way.sv
hw/icache_ctrl.sv
hw/icache_top.sv
tests/tb_icache.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# build and run the icache testbench with Verilator
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -j 0 \
    --top-module tb_icache \
    -f compile.f \
    -o sim_icache

./obj_dir/sim_icache 2>&1 | tee sim.log

if grep -q "Test failed" sim.log; then
    echo "icache simulation: FAIL"
    exit 1
fi
if ! grep -q "Test completed successfully" sim.log; then
    echo "icache simulation: no pass line in sim.log"
    exit 1
fi
echo "icache simulation: PASS"

// ==== tests/tb_icache.sv ====
`timescale 1ns/1ps
`include "icache_cfg.svh"

module tb_icache import icache_pkg::*; ();

    localparam int RESET_CYCLES   = 10;
    localparam int NUM_FETCH      = 24;
    localparam int TIMEOUT_CYCLES = RESET_CYCLES + NUM_FETCH * 12;
    localparam string DATA_FILE   = "tests/icache_testdata.txt";

    logic   clk;
    logic   reset_n;
    logic   cpu_req;
    word_t  cpu_addr;
    logic   cpu_ready;
    word_t  cpu_data;
    logic   mem_read;
    word_t  mem_addr;
    line_t  mem_line;
    logic   mem_ready;
    count_t access_count;
    count_t hit_count;

    // fetch list as read from the data file
    word_t fetch_addr [$];
    word_t fetch_data [$];
    logic  fetch_hit [$];

    // fetch in flight, seen by the memory model
    word_t cur_addr;
    int    cycle_count = 0;

    icache_top uut (
        .clk          (clk),
        .reset_n      (reset_n),
        .cpu_req      (cpu_req),
        .cpu_addr     (cpu_addr),
        .cpu_ready    (cpu_ready),
        .cpu_data     (cpu_data),
        .mem_read     (mem_read),
        .mem_addr     (mem_addr),
        .mem_line     (mem_line),
        .mem_ready    (mem_ready),
        .access_count (access_count),
        .hit_count    (hit_count)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    task automatic fail_run(input string msg);
        $display("%s", msg);
        $display("Test failed");
        $fatal(1, "run stopped at first error");
    endtask

    task automatic check_word(input string name, input word_t got, input word_t exp);
        if (got !== exp) begin
            fail_run($sformatf("mismatch %s: got 0x%h expected 0x%h", name, got, exp));
        end
    endtask

    task automatic check_count(input string name, input count_t got, input count_t exp);
        if (got !== exp) begin
            fail_run($sformatf("mismatch %s: got 0x%h expected 0x%h", name, got, exp));
        end
    endtask

    // memory contents depend on the word address only
    function automatic word_t mem_word(input word_t a);
        return a ^ 16'hA5C3;
    endfunction

    function automatic line_t build_line(input word_t base);
        line_t line;
        int    k;
        for (k = 0; k < `ICACHE_LINE_WORDS; k++) begin
            line[k * `ICACHE_WORD_W +: `ICACHE_WORD_W] = mem_word(base + word_t'(k));
        end
        return line;
    endfunction

    task automatic load_testdata();
        int          fd;
        int          n;
        string       text;
        int unsigned a;
        int unsigned d;
        int unsigned h;
        fd = $fopen(DATA_FILE, "r");
        if (fd == 0) begin
            fail_run("cannot open the test data file");
        end
        while (!$feof(fd)) begin
            text = "";
            n = $fgets(text, fd);
            // lines starting with # are column notes
            if (n > 0 && text.getc(0) != "#") begin
                if ($sscanf(text, "%h %h %h", a, d, h) == 3) begin
                    fetch_addr.push_back(word_t'(a));
                    fetch_data.push_back(word_t'(d));
                    fetch_hit.push_back(h != 0);
                end
            end
        end
        $fclose(fd);
    endtask

    // present one fetch and wait for cpu_ready
    task automatic run_fetch(input word_t addr, input word_t exp_data, input logic exp_hit);
        int   cycles;
        logic saw_mem;
        cycles  = 0;
        saw_mem = 1'b0;
        @(posedge clk);
        cpu_req  <= 1'b1;
        cpu_addr <= addr;
        cur_addr <= addr;
        // not yet sampled by the cache in this cycle
        @(negedge clk);
        do begin
            @(negedge clk);
            cycles++;
            if (mem_read) begin
                saw_mem = 1'b1;
            end
        end while (!cpu_ready);
        check_word("cpu_data", cpu_data, exp_data);
        if (exp_hit && (cycles != 1 || saw_mem)) begin
            fail_run($sformatf("fetch at 0x%h should hit but took %0d cycles", addr, cycles));
        end
        if (!exp_hit && !saw_mem) begin
            fail_run($sformatf("fetch at 0x%h should miss but never read memory", addr));
        end
    endtask

    // slow memory with a random latency per line
    initial begin : memory_model
        int    lat;
        word_t base;
        void'($urandom(86));
        mem_ready = 1'b0;
        mem_line  = '0;
        forever begin
            @(negedge clk);
            if (reset_n && mem_read) begin
                base = cur_addr & 16'hFFFC;
                check_word("mem_addr", mem_addr, base);
                lat = $urandom_range(8, 1);
                repeat (lat - 1) begin
                    @(negedge clk);
                    if (!mem_read) begin
                        fail_run("mem_read dropped before mem_ready");
                    end
                    check_word("mem_addr", mem_addr, base);
                end
                @(posedge clk);
                mem_ready <= 1'b1;
                mem_line  <= build_line(base);
                @(posedge clk);
                mem_ready <= 1'b0;
            end
        end
    end

    // longest miss takes 11 cycles
    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count > TIMEOUT_CYCLES) begin
            fail_run($sformatf("timeout, run not finished after %0d cycles", TIMEOUT_CYCLES));
        end
    end

    initial begin : main
        int i;
        int hits;
        reset_n  = 1'b0;
        cpu_req  = 1'b0;
        cpu_addr = '0;
        cur_addr = '0;
        hits     = 0;
        load_testdata();
        if (fetch_addr.size() != NUM_FETCH) begin
            fail_run($sformatf("data file holds %0d fetches, not %0d",
                               fetch_addr.size(), NUM_FETCH));
        end
        repeat (RESET_CYCLES) @(posedge clk);
        reset_n <= 1'b1;
        @(negedge clk);
        if (cpu_ready || mem_read) begin
            fail_run("cpu_ready or mem_read is high right after reset");
        end
        check_count("access_count", access_count, '0);
        check_count("hit_count", hit_count, '0);
        for (i = 0; i < NUM_FETCH; i++) begin
            if (fetch_data[i] !== mem_word(fetch_addr[i])) begin
                fail_run($sformatf("data file entry %0d disagrees with the memory pattern", i));
            end
            if (fetch_hit[i]) begin
                hits++;
            end
            run_fetch(fetch_addr[i], fetch_data[i], fetch_hit[i]);
        end
        @(posedge clk);
        cpu_req <= 1'b0;
        @(negedge clk);
        if (cpu_ready || mem_read) begin
            fail_run("cache still busy after the last fetch");
        end
        check_count("access_count", access_count, count_t'(NUM_FETCH));
        check_count("hit_count", hit_count, count_t'(hits));
        $display("Test completed successfully");
        $finish;
    end

endmodule

// ==== hw/icache_top.sv ====
`timescale 1ns/1ps
`include "icache_cfg.svh"

module icache_top import icache_pkg::*; (
    input  logic   clk,
    input  logic   reset_n,
    input  logic   cpu_req,
    input  word_t  cpu_addr,
    output logic   cpu_ready,
    output word_t  cpu_data,
    output logic   mem_read,
    output word_t  mem_addr,
    input  line_t  mem_line,
    input  logic   mem_ready,
    output count_t access_count,
    output count_t hit_count
);

    way_if lk ();

    icache_front u_front (
        .clk      (clk),
        .reset_n  (reset_n),
        .cpu_req  (cpu_req),
        .cpu_addr (cpu_addr),
        .lk       (lk)
    );

    // each way drives its own slot of the result arrays
    for (genvar g = 0; g < `ICACHE_WAYS; g++) begin : g_way
        cache_way #(
            .WAY (g)
        ) u_way (
            .clk     (clk),
            .reset_n (reset_n),
            .lk      (lk)
        );
    end

    icache_ctrl u_ctrl (
        .clk          (clk),
        .reset_n      (reset_n),
        .lk           (lk),
        .cpu_ready    (cpu_ready),
        .cpu_data     (cpu_data),
        .mem_read     (mem_read),
        .mem_addr     (mem_addr),
        .mem_line     (mem_line),
        .mem_ready    (mem_ready),
        .access_count (access_count),
        .hit_count    (hit_count)
    );

endmodule

// ==== hw/icache_ctrl.sv ====
`timescale 1ns/1ps

module icache_ctrl import icache_pkg::*; (
    input  logic   clk,
    input  logic   reset_n,
    way_if.ctrl    lk,
    output logic   cpu_ready,
    output word_t  cpu_data,
    output logic   mem_read,
    output word_t  mem_addr,
    input  line_t  mem_line,
    input  logic   mem_ready,
    output count_t access_count,
    output count_t hit_count
);

    typedef enum logic {
        LOOKUP = 1'b0,
        REFILL = 1'b1
    } state_e;

    state_e state_q;
    state_e state_d;

    // line aligned form of the pending address
    icache_addr_u line_addr;

    logic any_hit;
    logic hit_way;
    logic victim;
    logic victim_q;
    logic sel_way;
    logic refill_done;

    // two ways, so a way number is one bit
    assign any_hit = lk.hit[0] || lk.hit[1];
    assign hit_way = lk.hit[1];

    // way 0 unless way 0 was the last one used
    assign victim = lk.recent[0];

    always_comb begin
        line_addr          = lk.lookup_addr;
        line_addr.f.offset = '0;
    end

    assign mem_read    = (state_q == REFILL);
    assign mem_addr    = line_addr.flat;
    assign refill_done = mem_read && mem_ready;

    // way that becomes recent when the fetch completes
    assign sel_way = (state_q == REFILL) ? victim_q : hit_way;

    always_comb begin
        state_d   = state_q;
        cpu_ready = 1'b0;
        cpu_data  = lk.rd_word[hit_way];
        case (state_q)
            LOOKUP: begin
                if (lk.lookup_valid) begin
                    if (any_hit) begin
                        cpu_ready = 1'b1;
                    end else begin
                        state_d = REFILL;
                    end
                end
            end
            REFILL: begin
                if (mem_ready) begin
                    // forward the word straight from the incoming line
                    cpu_ready = 1'b1;
                    cpu_data  = line_word(mem_line, lk.lookup_addr.f.offset);
                    state_d   = LOOKUP;
                end
            end
            default: begin
                state_d = LOOKUP;
            end
        endcase
    end

    assign lk.done       = cpu_ready;
    assign lk.recent_upd = cpu_ready;
    assign lk.fill_line  = mem_line;

    always_comb begin
        lk.set_recent          = '0;
        lk.set_recent[sel_way] = 1'b1;
        lk.fill_en             = '0;
        lk.fill_en[victim_q]   = refill_done;
    end

    always_ff @(posedge clk) begin
        if (!reset_n) begin
            state_q <= LOOKUP;
        end else begin
            state_q <= state_d;
        end
    end

    // victim chosen on the miss cycle
    always_ff @(posedge clk) begin
        if (state_q == LOOKUP && state_d == REFILL) begin
            victim_q <= victim;
        end
    end

    // statistics
    always_ff @(posedge clk) begin
        if (!reset_n) begin
            access_count <= '0;
            hit_count    <= '0;
        end else if (cpu_ready) begin
            access_count <= access_count + 1'b1;
            if (state_q == LOOKUP) begin
                hit_count <= hit_count + 1'b1;
            end
        end
    end

    a_fill_onehot: assert property (
        @(posedge clk) disable iff (!reset_n)
        $onehot0(lk.fill_en)
    ) else $error("fill_en set for more than one way");

    // memory request held until mem_ready
    a_mem_hold: assert property (
        @(posedge clk) disable iff (!reset_n)
        mem_read && !mem_ready |=> mem_read && $stable(mem_addr)
    ) else $error("memory request dropped or changed before mem_ready");

endmodule

// ==== hw/cache_way.sv ====
`timescale 1ns/1ps
`include "icache_cfg.svh"

module cache_way import icache_pkg::*; #(
    parameter int WAY = 0
) (
    input  logic clk,
    input  logic reset_n,
    way_if.way   lk
);

    // per-set storage of this way
    tag_t  tag_mem [`ICACHE_SETS];
    line_t line_mem [`ICACHE_SETS];
    logic [`ICACHE_SETS-1:0] valid_q;
    logic [`ICACHE_SETS-1:0] recent_q;

    index_t  idx;
    tag_t    req_tag;
    offset_t req_off;
    line_t   rd_line;

    assign idx     = lk.lookup_addr.f.index;
    assign req_tag = lk.lookup_addr.f.tag;
    assign req_off = lk.lookup_addr.f.offset;

    // combinational read of the indexed set
    assign rd_line = line_mem[idx];

    assign lk.hit[WAY]     = valid_q[idx] && (tag_mem[idx] == req_tag);
    assign lk.recent[WAY]  = recent_q[idx];
    assign lk.rd_word[WAY] = line_word(rd_line, req_off);

    // valid and recency bits
    always_ff @(posedge clk) begin
        if (!reset_n) begin
            valid_q  <= '0;
            recent_q <= '0;
        end else if (lk.fill_en[WAY]) begin
            valid_q[idx]  <= 1'b1;
            recent_q[idx] <= lk.set_recent[WAY];
        end else if (lk.recent_upd) begin
            // other way was touched, just follow the new recency
            recent_q[idx] <= lk.set_recent[WAY];
        end
    end

    // tag and line payload
    always_ff @(posedge clk) begin
        if (lk.fill_en[WAY]) begin
            tag_mem[idx]  <= req_tag;
            line_mem[idx] <= lk.fill_line;
        end
    end

    // a line is only fetched after this way missed on it
    a_fill_on_miss: assert property (
        @(posedge clk) disable iff (!reset_n)
        lk.fill_en[WAY] |-> !lk.hit[WAY]
    ) else $error("way %0d refilled a line it already holds", WAY);

endmodule

// ==== hw/icache_front.sv ====
`timescale 1ns/1ps

module icache_front import icache_pkg::*; (
    input  logic  clk,
    input  logic  reset_n,
    input  logic  cpu_req,
    input  word_t cpu_addr,
    way_if.front  lk
);

    // a fetch has been taken and is not yet answered
    logic busy_q;

    // captured address, decoded through the union
    icache_addr_u addr_q;

    always_ff @(posedge clk) begin
        if (!reset_n) begin
            busy_q <= 1'b0;
        end else if (!busy_q) begin
            busy_q <= cpu_req;
        end else if (lk.done) begin
            // idle again on the edge that answers
            busy_q <= 1'b0;
        end
    end

    // only loaded when idle so the ways see a steady index
    always_ff @(posedge clk) begin
        if (!busy_q && cpu_req) begin
            addr_q.flat <= cpu_addr;
        end
    end

    assign lk.lookup_valid = busy_q;
    assign lk.lookup_addr  = addr_q;

    // CPU must hold request and address until cpu_ready
    a_cpu_hold: assert property (
        @(posedge clk) disable iff (!reset_n)
        lk.lookup_valid |-> cpu_req && (cpu_addr == lk.lookup_addr.flat)
    ) else $error("cpu request changed while pending");

endmodule

// ==== hw/way_if.sv ====
`timescale 1ns/1ps
`include "icache_cfg.svh"

interface way_if import icache_pkg::*; ();

    // request held by the front
    logic         lookup_valid;
    icache_addr_u lookup_addr;

    // lookup results, one slot per way
    logic  hit [`ICACHE_WAYS];
    logic  recent [`ICACHE_WAYS];
    word_t rd_word [`ICACHE_WAYS];

    // write side driven by the controller
    logic [`ICACHE_WAYS-1:0] fill_en;
    line_t                   fill_line;
    logic [`ICACHE_WAYS-1:0] set_recent;
    logic                    recent_upd;

    // fetch answered, front may go idle
    logic done;

    modport front (output lookup_valid, output lookup_addr, input done);

    modport way (
        input  lookup_addr,
        output hit, recent, rd_word,
        input  fill_en, fill_line, set_recent, recent_upd
    );

    modport ctrl (
        input  lookup_valid, lookup_addr, hit, recent, rd_word,
        output fill_en, fill_line, set_recent, recent_upd, done
    );

endinterface

// ==== hw/icache_pkg.sv ====
`include "icache_cfg.svh"

package icache_pkg;

    // one instruction word or one address
    typedef logic [`ICACHE_WORD_W-1:0] word_t;

    // word 0 sits in the low bits
    typedef logic [`ICACHE_LINE_W-1:0] line_t;

    typedef logic [`ICACHE_TAG_W-1:0] tag_t;
    typedef logic [`ICACHE_INDEX_W-1:0] index_t;
    typedef logic [`ICACHE_OFFSET_W-1:0] offset_t;

    typedef logic [`ICACHE_COUNT_W-1:0] count_t;

    // field view of a fetch address
    typedef struct packed {
        tag_t    tag;
        index_t  index;
        offset_t offset;
    } icache_addr_s;

    // same address seen flat or split into fields
    typedef union packed {
        word_t        flat;
        icache_addr_s f;
    } icache_addr_u;

    // pick one word out of a line
    function automatic word_t line_word(line_t line, offset_t offset);
        return line[offset * `ICACHE_WORD_W +: `ICACHE_WORD_W];
    endfunction

endpackage

// ==== hw/icache_cfg.svh ====
`ifndef ICACHE_CFG_SVH
`define ICACHE_CFG_SVH

// instruction word and address width
`define ICACHE_WORD_W 16

// words per cache line
`define ICACHE_LINE_WORDS 4

// sets per way
`define ICACHE_SETS 4

// fixed at two by the one-recent-bit replacement
`define ICACHE_WAYS 2

// address split derived from the sizes above
`define ICACHE_OFFSET_W $clog2(`ICACHE_LINE_WORDS)
`define ICACHE_INDEX_W $clog2(`ICACHE_SETS)
`define ICACHE_TAG_W (`ICACHE_WORD_W - `ICACHE_INDEX_W - `ICACHE_OFFSET_W)

// full line as delivered by memory
`define ICACHE_LINE_W (`ICACHE_LINE_WORDS * `ICACHE_WORD_W)

// statistics counter width
`define ICACHE_COUNT_W 16

`endif
